/* sources.f */
hdl/eth_pkg.sv
hdl/eth_hdr_if.sv
hdl/eth_payload_if.sv
hdl/eth_rr_arbiter.sv
hdl/eth_payload_skid.sv
hdl/eth_mux_2.sv
hdl/eth_mux_top.sv
tb/eth_mux_checker.sv
tb/tb_eth_mux.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_eth_mux -f sources.f -o sim_eth_mux \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_eth_mux > sim.log 2>&1
cat sim.log
grep -qx "All checks passed" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* tb/tb_eth_mux.sv */
module tb_eth_mux;
    import eth_pkg::*;

    localparam int frames_per_port = 12;
    localparam int disable_cycles = 100;

    logic                  clk;
    logic                  rst;
    logic                  enable;
    logic [1:0]            hdr_valid;
    logic [1:0]            hdr_ready;
    logic [mac_width-1:0]  dest_mac [2];
    logic [mac_width-1:0]  src_mac [2];
    logic [type_width-1:0] eth_type [2];
    logic [data_width-1:0] tdata [2];
    logic [1:0]            tvalid;
    logic [1:0]            tready;
    logic [1:0]            tlast;
    logic [1:0]            tuser;

    logic                  out_hdr_valid;
    logic                  out_hdr_ready;
    logic [mac_width-1:0]  out_dest_mac;
    logic [mac_width-1:0]  out_src_mac;
    logic [type_width-1:0] out_eth_type;
    logic [data_width-1:0] out_tdata;
    logic                  out_tvalid;
    logic                  out_tready;
    logic                  out_tlast;
    logic                  out_tuser;

    // payload lengths are drawn once and shared with the checker
    int     frame_len [2][frames_per_port];
    int     limit;
    integer seed;
    logic   done;
    int     frame_count;
    int     byte_count;
    int     error_count;

    eth_mux_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .enable         (enable),
        .in_0_hdr_valid (hdr_valid[0]),
        .in_0_hdr_ready (hdr_ready[0]),
        .in_0_dest_mac  (dest_mac[0]),
        .in_0_src_mac   (src_mac[0]),
        .in_0_eth_type  (eth_type[0]),
        .in_0_tdata     (tdata[0]),
        .in_0_tvalid    (tvalid[0]),
        .in_0_tready    (tready[0]),
        .in_0_tlast     (tlast[0]),
        .in_0_tuser     (tuser[0]),
        .in_1_hdr_valid (hdr_valid[1]),
        .in_1_hdr_ready (hdr_ready[1]),
        .in_1_dest_mac  (dest_mac[1]),
        .in_1_src_mac   (src_mac[1]),
        .in_1_eth_type  (eth_type[1]),
        .in_1_tdata     (tdata[1]),
        .in_1_tvalid    (tvalid[1]),
        .in_1_tready    (tready[1]),
        .in_1_tlast     (tlast[1]),
        .in_1_tuser     (tuser[1]),
        .out_hdr_valid  (out_hdr_valid),
        .out_hdr_ready  (out_hdr_ready),
        .out_dest_mac   (out_dest_mac),
        .out_src_mac    (out_src_mac),
        .out_eth_type   (out_eth_type),
        .out_tdata      (out_tdata),
        .out_tvalid     (out_tvalid),
        .out_tready     (out_tready),
        .out_tlast      (out_tlast),
        .out_tuser      (out_tuser)
    );

    eth_mux_checker #(.frames(frames_per_port)) i_checker (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin : stimulus
        int   total;
        int   hdr_frame [2];
        int   pay_frame [2];
        int   pay_idx [2];
        int   step;
        int   dis_left;
        logic last;
        seed = 32'hce3d;
        total = 0;
        rst = 1'b1;
        enable = 1'b1;
        hdr_valid = '0;
        tvalid = '0;
        tlast = '0;
        tuser = '0;
        out_hdr_ready = 1'b0;
        out_tready = 1'b0;
        for (int p = 0; p < 2; p++) begin
            dest_mac[p] = '0;
            src_mac[p] = '0;
            eth_type[p] = '0;
            tdata[p] = '0;
            hdr_frame[p] = 0;
            pay_frame[p] = 0;
            pay_idx[p] = 0;
            for (int f = 0; f < frames_per_port; f++) begin
                frame_len[p][f] = 1 + int'({$random(seed)} % 16);
                total += frame_len[p][f];
            end
        end
        // worst case about four cycles per byte under stalls, plus frame overhead
        limit = total * 4 + 2 * frames_per_port * 20 + disable_cycles + 200;
        step = 0;
        dis_left = -1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        forever begin
            @(posedge clk);
            step++;
            out_tready <= ({$random(seed)} % 4) != 0;
            out_hdr_ready <= ({$random(seed)} % 3) != 0;
            // drop enable once while a frame is moving
            if (dis_left > 0) begin
                dis_left--;
                if (dis_left == 0) begin
                    enable <= 1'b1;
                end
            end else if (dis_left < 0 && step >= 120 && tready != 2'b00) begin
                enable <= 1'b0;
                dis_left = disable_cycles;
            end
            for (int p = 0; p < 2; p++) begin
                if (hdr_valid[p] && hdr_ready[p]) begin
                    hdr_frame[p]++;
                end
                if (hdr_frame[p] < frames_per_port) begin
                    hdr_valid[p] <= 1'b1;
                    dest_mac[p] <= {16'h0200, 8'(p), 8'(hdr_frame[p]), 16'hd0d0};
                    src_mac[p] <= {16'h0600, 8'(hdr_frame[p]), 8'(p), 16'h5a5a};
                    eth_type[p] <= {8'h88, 4'(p), 4'(hdr_frame[p])};
                end else begin
                    hdr_valid[p] <= 1'b0;
                end
                if (tvalid[p] && tready[p]) begin
                    if (pay_idx[p] == frame_len[p][pay_frame[p]] - 1) begin
                        pay_frame[p]++;
                        pay_idx[p] = 0;
                    end else begin
                        pay_idx[p]++;
                    end
                end
                if (pay_frame[p] < frames_per_port) begin
                    last = pay_idx[p] == frame_len[p][pay_frame[p]] - 1;
                    tvalid[p] <= 1'b1;
                    tdata[p] <= 8'(p * 64 + pay_frame[p] * 13 + pay_idx[p] * 7);
                    tlast[p] <= last;
                    tuser[p] <= last && ((p + pay_frame[p]) % 3 == 2);
                end else begin
                    tvalid[p] <= 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        int cycle;
        cycle = 0;
        @(negedge rst);
        while (!done && cycle < limit) begin
            @(posedge clk);
            cycle++;
        end
        if (!done) begin
            $display("timeout after %0d cycles, frames did not finish (%0d of %0d frames, %0d errors)",
                     cycle, frame_count, 2 * frames_per_port, error_count);
            $display("Checks failed");
        end else begin
            // extra bytes after the last frame still get caught here
            repeat (20) @(posedge clk);
            $display("summary: %0d frames, %0d bytes, %0d errors",
                     frame_count, byte_count, error_count);
            if (error_count == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
        end
        $finish;
    end

endmodule

/* tb/eth_mux_checker.sv */
module eth_mux_checker #(
    parameter int frames = 12
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           enable,
    input  logic                           out_hdr_valid,
    input  logic                           out_hdr_ready,
    input  logic [eth_pkg::mac_width-1:0]  out_dest_mac,
    input  logic [eth_pkg::mac_width-1:0]  out_src_mac,
    input  logic [eth_pkg::type_width-1:0] out_eth_type,
    input  logic [eth_pkg::data_width-1:0] out_tdata,
    input  logic                           out_tvalid,
    input  logic                           out_tready,
    input  logic                           out_tlast,
    input  logic                           out_tuser,
    input  int                             frame_len [2][frames],
    output logic                           done,
    output int                             frame_count,
    output int                             byte_count,
    output int                             error_count
);
    import eth_pkg::*;

    localparam int total_frames = 2 * frames;

    int   hdr_count;
    int   hdr_starts;
    int   pay_frame;
    int   pay_idx;
    int   bytes;
    int   errors;
    logic prev_hdr_valid;
    logic prev_enable;

    // expected {dest, src, type}
    function automatic logic [2*mac_width+type_width-1:0] ref_header(input int p, input int f);
        return {16'h0200, 8'(p), 8'(f), 16'hd0d0,
                16'h0600, 8'(f), 8'(p), 16'h5a5a,
                8'h88, 4'(p), 4'(f)};
    endfunction

    function automatic logic [data_width-1:0] ref_byte(input int p, input int f, input int i);
        return data_width'(p * 64 + f * 13 + i * 7);
    endfunction

    // every third frame is flagged bad on its last byte
    function automatic logic ref_bad(input int p, input int f);
        return (p + f) % 3 == 2;
    endfunction

    function automatic int total_bytes();
        int sum;
        sum = 0;
        for (int p = 0; p < 2; p++) begin
            for (int f = 0; f < frames; f++) begin
                sum += frame_len[p][f];
            end
        end
        return sum;
    endfunction

    task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
        errors++;
        $display("Error %s at %0t: expected %0h, actual %0h", name, $time, exp, act);
    endtask

    task automatic event_error(input string msg);
        errors++;
        $display("%s at %0t", msg, $time);
    endtask

    always @(posedge clk) begin : compare
        logic [2*mac_width+type_width-1:0] exp_hdr;
        int   p;
        int   f;
        logic exp_last;
        if (rst) begin
            hdr_count = 0;
            hdr_starts = 0;
            pay_frame = 0;
            pay_idx = 0;
            bytes = 0;
            errors = 0;
            prev_hdr_valid = 1'b0;
            prev_enable = 1'b1;
        end else begin
            // a new header comes from a start decided in the previous cycle
            if (out_hdr_valid && !prev_hdr_valid) begin
                hdr_starts++;
                if (!prev_enable) begin
                    event_error("a new output header started while enable was low");
                end
            end
            // both ports always have headers waiting, so grants alternate 0, 1, 0, ...
            if (out_hdr_valid && out_hdr_ready) begin
                if (hdr_count >= total_frames) begin
                    event_error("an output header arrived after the last frame");
                end else begin
                    p = hdr_count % 2;
                    f = hdr_count / 2;
                    exp_hdr = ref_header(p, f);
                    if (out_dest_mac !== exp_hdr[2*mac_width+type_width-1 -: mac_width]) begin
                        value_error("header dest_mac",
                                    64'(exp_hdr[2*mac_width+type_width-1 -: mac_width]),
                                    64'(out_dest_mac));
                    end
                    if (out_src_mac !== exp_hdr[mac_width+type_width-1 -: mac_width]) begin
                        value_error("header src_mac",
                                    64'(exp_hdr[mac_width+type_width-1 -: mac_width]),
                                    64'(out_src_mac));
                    end
                    if (out_eth_type !== exp_hdr[type_width-1:0]) begin
                        value_error("header eth_type", 64'(exp_hdr[type_width-1:0]),
                                    64'(out_eth_type));
                    end
                    hdr_count++;
                end
            end
            if (out_tvalid && out_tready) begin
                if (pay_frame >= total_frames) begin
                    event_error("an output byte arrived after the last frame");
                end else begin
                    p = pay_frame % 2;
                    f = pay_frame / 2;
                    exp_last = pay_idx == frame_len[p][f] - 1;
                    if (out_tdata !== ref_byte(p, f, pay_idx)) begin
                        value_error("payload tdata", 64'(ref_byte(p, f, pay_idx)),
                                    64'(out_tdata));
                    end
                    if (out_tlast !== exp_last) begin
                        value_error("payload tlast", 64'(exp_last), 64'(out_tlast));
                    end
                    if (out_tuser !== (exp_last && ref_bad(p, f))) begin
                        value_error("payload tuser", 64'(exp_last && ref_bad(p, f)),
                                    64'(out_tuser));
                    end
                    bytes++;
                    if (out_tlast) begin
                        pay_frame++;
                        pay_idx = 0;
                        if (pay_frame == total_frames && bytes != total_bytes()) begin
                            value_error("byte count", 64'(total_bytes()), 64'(bytes));
                        end
                    end else begin
                        pay_idx++;
                    end
                end
            end
            // a frame open when enable fell must have drained by now
            if (enable && !prev_enable && hdr_starts != pay_frame) begin
                event_error("a frame started before enable fell did not complete");
            end
            prev_hdr_valid = out_hdr_valid;
            prev_enable = enable;
        end
        done <= pay_frame == total_frames && hdr_count == total_frames;
        frame_count <= pay_frame;
        byte_count <= bytes;
        error_count <= errors;
    end

endmodule

/* hdl/eth_mux_top.sv */
module eth_mux_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           enable,

    input  logic                           in_0_hdr_valid,
    output logic                           in_0_hdr_ready,
    input  logic [eth_pkg::mac_width-1:0]  in_0_dest_mac,
    input  logic [eth_pkg::mac_width-1:0]  in_0_src_mac,
    input  logic [eth_pkg::type_width-1:0] in_0_eth_type,
    input  logic [eth_pkg::data_width-1:0] in_0_tdata,
    input  logic                           in_0_tvalid,
    output logic                           in_0_tready,
    input  logic                           in_0_tlast,
    input  logic                           in_0_tuser,

    input  logic                           in_1_hdr_valid,
    output logic                           in_1_hdr_ready,
    input  logic [eth_pkg::mac_width-1:0]  in_1_dest_mac,
    input  logic [eth_pkg::mac_width-1:0]  in_1_src_mac,
    input  logic [eth_pkg::type_width-1:0] in_1_eth_type,
    input  logic [eth_pkg::data_width-1:0] in_1_tdata,
    input  logic                           in_1_tvalid,
    output logic                           in_1_tready,
    input  logic                           in_1_tlast,
    input  logic                           in_1_tuser,

    output logic                           out_hdr_valid,
    input  logic                           out_hdr_ready,
    output logic [eth_pkg::mac_width-1:0]  out_dest_mac,
    output logic [eth_pkg::mac_width-1:0]  out_src_mac,
    output logic [eth_pkg::type_width-1:0] out_eth_type,
    output logic [eth_pkg::data_width-1:0] out_tdata,
    output logic                           out_tvalid,
    input  logic                           out_tready,
    output logic                           out_tlast,
    output logic                           out_tuser
);
    import eth_pkg::*;

    logic [sel_width-1:0] select;
    logic                 ready_early;

    eth_hdr_if     hdr_in0 ();
    eth_hdr_if     hdr_in1 ();
    eth_hdr_if     hdr_out ();
    eth_payload_if pay_in0 ();
    eth_payload_if pay_in1 ();
    // qualified bytes from the mux into the skid stage
    eth_payload_if pay_mid ();
    eth_payload_if pay_out ();

    assign hdr_in0.hdr_valid = in_0_hdr_valid;
    assign hdr_in0.dest_mac = in_0_dest_mac;
    assign hdr_in0.src_mac = in_0_src_mac;
    assign hdr_in0.eth_type = in_0_eth_type;
    assign in_0_hdr_ready = hdr_in0.hdr_ready;
    assign pay_in0.tdata = in_0_tdata;
    assign pay_in0.tvalid = in_0_tvalid;
    assign pay_in0.tlast = in_0_tlast;
    assign pay_in0.tuser = in_0_tuser;
    assign in_0_tready = pay_in0.tready;

    assign hdr_in1.hdr_valid = in_1_hdr_valid;
    assign hdr_in1.dest_mac = in_1_dest_mac;
    assign hdr_in1.src_mac = in_1_src_mac;
    assign hdr_in1.eth_type = in_1_eth_type;
    assign in_1_hdr_ready = hdr_in1.hdr_ready;
    assign pay_in1.tdata = in_1_tdata;
    assign pay_in1.tvalid = in_1_tvalid;
    assign pay_in1.tlast = in_1_tlast;
    assign pay_in1.tuser = in_1_tuser;
    assign in_1_tready = pay_in1.tready;

    assign out_hdr_valid = hdr_out.hdr_valid;
    assign out_dest_mac = hdr_out.dest_mac;
    assign out_src_mac = hdr_out.src_mac;
    assign out_eth_type = hdr_out.eth_type;
    assign hdr_out.hdr_ready = out_hdr_ready;
    assign out_tdata = pay_out.tdata;
    assign out_tvalid = pay_out.tvalid;
    assign out_tlast = pay_out.tlast;
    assign out_tuser = pay_out.tuser;
    assign pay_out.tready = out_tready;

    eth_rr_arbiter i_arbiter (
        .clk    (clk),
        .rst    (rst),
        .in0    (hdr_in0),
        .in1    (hdr_in1),
        .select (select)
    );

    eth_mux_2 i_mux (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .select      (select),
        .in0         (hdr_in0),
        .in1         (hdr_in1),
        .p0          (pay_in0),
        .p1          (pay_in1),
        .out_hdr     (hdr_out),
        .out_pay     (pay_mid),
        .ready_early (ready_early)
    );

    eth_payload_skid i_skid (
        .clk         (clk),
        .rst         (rst),
        .in          (pay_mid),
        .ready_early (ready_early),
        .out         (pay_out)
    );

endmodule

/* hdl/eth_mux_2.sv */
module eth_mux_2 (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          enable,
    input  logic [eth_pkg::sel_width-1:0] select,
    eth_hdr_if.sink                       in0,
    eth_hdr_if.sink                       in1,
    eth_payload_if.sink                   p0,
    eth_payload_if.sink                   p1,
    eth_hdr_if.source                     out_hdr,
    eth_payload_if.source                 out_pay,
    input  logic                          ready_early
);
    import eth_pkg::*;

    // frame state
    logic [sel_width-1:0] select_reg;
    logic [sel_width-1:0] select_next;
    logic                 frame_reg;
    logic                 frame_next;
    logic                 start;

    // per port handshakes
    logic [num_ports-1:0] hdr_ready_reg;
    logic [num_ports-1:0] hdr_ready_next;
    logic [num_ports-1:0] tready_reg;
    logic [num_ports-1:0] tready_next;

    // output header register
    logic                  hdr_valid_reg;
    logic                  hdr_valid_next;
    logic [mac_width-1:0]  dest_mac_reg;
    logic [mac_width-1:0]  src_mac_reg;
    logic [type_width-1:0] eth_type_reg;

    // header offered by the port the arbiter points at
    logic                  sel_hdr_valid;
    logic [mac_width-1:0]  sel_dest_mac;
    logic [mac_width-1:0]  sel_src_mac;
    logic [type_width-1:0] sel_eth_type;

    // payload of the port owning the current frame
    logic [data_width-1:0] cur_tdata;
    logic                  cur_tvalid;
    logic                  cur_tready;
    logic                  cur_tlast;
    logic                  cur_tuser;

    always_comb begin
        if (select == '0) begin
            sel_hdr_valid = in0.hdr_valid;
            sel_dest_mac = in0.dest_mac;
            sel_src_mac = in0.src_mac;
            sel_eth_type = in0.eth_type;
        end else begin
            sel_hdr_valid = in1.hdr_valid;
            sel_dest_mac = in1.dest_mac;
            sel_src_mac = in1.src_mac;
            sel_eth_type = in1.eth_type;
        end
    end

    always_comb begin
        if (select_reg == '0) begin
            cur_tdata = p0.tdata;
            cur_tvalid = p0.tvalid;
            cur_tlast = p0.tlast;
            cur_tuser = p0.tuser;
        end else begin
            cur_tdata = p1.tdata;
            cur_tvalid = p1.tvalid;
            cur_tlast = p1.tlast;
            cur_tuser = p1.tuser;
        end
    end

    assign cur_tready = tready_reg[select_reg];

    always_comb begin
        select_next = select_reg;
        frame_next = frame_reg;
        start = 1'b0;
        hdr_ready_next = '0;
        tready_next = '0;
        hdr_valid_next = hdr_valid_reg & ~out_hdr.hdr_ready;

        if (frame_reg) begin
            // frame ends on an accepted last byte
            if (cur_tvalid && cur_tready) begin
                frame_next = ~cur_tlast;
            end
        end else if (enable && !hdr_valid_reg && sel_hdr_valid) begin
            start = 1'b1;
            frame_next = 1'b1;
            select_next = select;
            hdr_ready_next[select] = 1'b1;
            hdr_valid_next = 1'b1;
        end

        // only the owning port sees tready
        tready_next[select_next] = ready_early & frame_next;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            select_reg <= '0;
            frame_reg <= 1'b0;
            hdr_ready_reg <= '0;
            tready_reg <= '0;
            hdr_valid_reg <= 1'b0;
        end else begin
            select_reg <= select_next;
            frame_reg <= frame_next;
            hdr_ready_reg <= hdr_ready_next;
            tready_reg <= tready_next;
            hdr_valid_reg <= hdr_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dest_mac_reg <= sel_dest_mac;
            src_mac_reg <= sel_src_mac;
            eth_type_reg <= sel_eth_type;
        end
    end

    assign in0.hdr_ready = hdr_ready_reg[0];
    assign in1.hdr_ready = hdr_ready_reg[1];
    assign p0.tready = tready_reg[0];
    assign p1.tready = tready_reg[1];

    assign out_hdr.hdr_valid = hdr_valid_reg;
    assign out_hdr.dest_mac = dest_mac_reg;
    assign out_hdr.src_mac = src_mac_reg;
    assign out_hdr.eth_type = eth_type_reg;

    // tvalid toward the skid stage already means a completed transfer
    assign out_pay.tdata = cur_tdata;
    assign out_pay.tvalid = cur_tvalid & cur_tready & frame_reg;
    assign out_pay.tlast = cur_tlast;
    assign out_pay.tuser = cur_tuser;

endmodule

/* hdl/eth_payload_skid.sv */
module eth_payload_skid (
    input  logic          clk,
    input  logic          rst,
    eth_payload_if.sink   in,
    output logic          ready_early,
    eth_payload_if.source out
);
    import eth_pkg::*;

    // beat layout is {tuser, tlast, tdata}
    logic [data_width+1:0] in_beat;
    logic [data_width+1:0] out_beat;
    logic [data_width+1:0] temp_beat;

    logic out_valid;
    logic temp_valid;
    // registered early ready gates input capture
    logic ready_reg;

    logic load_out;
    logic load_temp;
    logic drain_temp;

    assign in_beat = {in.tuser, in.tlast, in.tdata};

    // room next cycle if the output moves, both stages are empty,
    // or the temp stage stays free because nothing arrives now
    assign ready_early = out.tready | (~temp_valid & ~out_valid) | (~temp_valid & ~in.tvalid);

    assign load_out = ready_reg & (out.tready | ~out_valid);
    assign load_temp = ready_reg & ~out.tready & out_valid;
    assign drain_temp = ~ready_reg & out.tready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_reg <= 1'b0;
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (load_out) begin
                out_valid <= in.tvalid;
            end else if (drain_temp) begin
                out_valid <= temp_valid;
            end
            if (load_temp) begin
                temp_valid <= in.tvalid;
            end else if (drain_temp) begin
                temp_valid <= 1'b0;
            end
        end
    end

    // beat payload follows the valid flags above
    always_ff @(posedge clk) begin
        if (load_out) begin
            out_beat <= in_beat;
        end else if (drain_temp) begin
            out_beat <= temp_beat;
        end
        if (load_temp) begin
            temp_beat <= in_beat;
        end
    end

    assign in.tready = ready_reg;

    assign out.tvalid = out_valid;
    assign out.tdata = out_beat[data_width-1:0];
    assign out.tlast = out_beat[data_width];
    assign out.tuser = out_beat[data_width+1];

endmodule

/* hdl/eth_rr_arbiter.sv */
module eth_rr_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    eth_hdr_if.monitor                    in0,
    eth_hdr_if.monitor                    in1,
    output logic [eth_pkg::sel_width-1:0] select
);
    import eth_pkg::*;

    logic [num_ports-1:0] pending;
    logic [num_ports-1:0] granted;
    // port that wins when both headers are pending
    logic [sel_width-1:0] prio;

    assign pending = {in1.hdr_valid, in0.hdr_valid};
    assign granted = {in1.hdr_valid & in1.hdr_ready, in0.hdr_valid & in0.hdr_ready};

    always_comb begin
        case (pending)
            2'b01: begin
                select = '0;
            end
            2'b10: begin
                select = sel_width'(1);
            end
            default: begin
                // contention or idle follows the priority pointer
                select = prio;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prio <= '0;
        end else if (|granted) begin
            // hand priority to the port that was not just served
            prio <= granted[0] ? sel_width'(1) : '0;
        end
    end

endmodule

/* hdl/eth_payload_if.sv */
interface eth_payload_if;
    import eth_pkg::*;

    logic [data_width-1:0] tdata;
    logic                  tvalid;
    logic                  tready;
    logic                  tlast;
    // bad frame flag that matters on the tlast beat
    logic                  tuser;

    modport source (
        output tdata, tvalid, tlast, tuser,
        input  tready
    );

    modport sink (
        input  tdata, tvalid, tlast, tuser,
        output tready
    );

    modport monitor (
        input tdata, tvalid, tready, tlast, tuser
    );

endinterface

/* hdl/eth_hdr_if.sv */
interface eth_hdr_if;
    import eth_pkg::*;

    logic                  hdr_valid;
    logic                  hdr_ready;
    logic [mac_width-1:0]  dest_mac;
    logic [mac_width-1:0]  src_mac;
    logic [type_width-1:0] eth_type;

    // fields are held stable while hdr_valid is high
    modport source (
        output hdr_valid, dest_mac, src_mac, eth_type,
        input  hdr_ready
    );

    modport sink (
        input  hdr_valid, dest_mac, src_mac, eth_type,
        output hdr_ready
    );

    // observe only for the arbiter
    modport monitor (
        input hdr_valid, hdr_ready, dest_mac, src_mac, eth_type
    );

endinterface

/* hdl/eth_pkg.sv */
package eth_pkg;

    // ethernet header fields
    localparam int mac_width = 48;
    localparam int type_width = 16;

    // payload stream is one byte per beat
    localparam int data_width = 8;

    // mux geometry
    localparam int num_ports = 2;
    localparam int sel_width = $clog2(num_ports);

endpackage
